/* Bender.yml */
package:
  name: ita_softmax

sources:
  - include_dirs:
      - .
    files:
      - softmax_data_pkg.sv
      - softmax_ctrl_pkg.sv
      - softmax_buffer.sv
      - softmax_accum.sv
      - softmax_fifo.sv
      - softmax_div_dispatch.sv
      - softmax_stream.sv
      - ita_softmax_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ita_softmax_asserts.sv
      - tb_ita_softmax.sv

/* ita_softmax_top.sv */
// Softmax unit top level
// Accumulation, division dispatch and streaming around the max and sum buffers
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module ita_softmax_top
  import softmax_data_pkg::*;
  import softmax_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  step_e                    step_i,
  input  logic                     calc_en_i,
  input  seq_len_t                 seq_len_i,
  input  tile_cnt_t                tile_s_i,
  input  score_vec_t               requant_oup_i,
  input  score_t                   max_i,
  input  logic                     calc_stream_soft_en_i,
  input  row_vec_t                 inp_i,
  input  counter_t                 tile_y_i,
  input  counter_t                 inner_tile_i,
  output acc_t                     div_inp_o,
  output logic [`SOFT_NUM_DIV-1:0] div_valid_o,
  input  logic [`SOFT_NUM_DIV-1:0] div_ready_i,
  input  logic [`SOFT_NUM_DIV-1:0] div_valid_i,
  output logic [`SOFT_NUM_DIV-1:0] div_ready_o,
  input  acc_t [`SOFT_NUM_DIV-1:0] div_oup_i,
  output logic                     pop_softmax_fifo_o,
  output logic                     softmax_done_o,
  output row_vec_t                 inp_stream_soft_o
);

  logic [1:0] max_rd_en, acc_rd_en;
  buf_addr_t [1:0] max_rd_addr, acc_rd_addr;
  acc_t [1:0] max_rd_data, acc_rd_data;
  logic max_wr_en, accum_wr_en, div_wr_en, acc_wr_en;
  buf_addr_t max_wr_addr, accum_wr_addr, div_wr_addr, acc_wr_addr;
  acc_t max_wr_data, accum_wr_data, div_wr_data, acc_wr_data;
  logic push;
  acc_t push_data;
  logic stream_rd_en;
  buf_addr_t stream_rd_addr;

  assign max_rd_en[1]   = stream_rd_en;
  assign max_rd_addr[1] = stream_rd_addr;
  assign acc_rd_en[1]   = stream_rd_en;
  assign acc_rd_addr[1] = stream_rd_addr;

  // Quotient writes win over accumulation write back
  assign acc_wr_en   = div_wr_en || accum_wr_en;
  assign acc_wr_addr = div_wr_en ? div_wr_addr : accum_wr_addr;
  assign acc_wr_data = div_wr_en ? div_wr_data : accum_wr_data;

  softmax_buffer u_max_buf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (max_rd_en),
    .rd_addr_i (max_rd_addr),
    .rd_data_o (max_rd_data),
    .wr_en_i   (max_wr_en),
    .wr_addr_i (max_wr_addr),
    .wr_data_i (max_wr_data)
  );

  softmax_buffer u_acc_buf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (acc_rd_en),
    .rd_addr_i (acc_rd_addr),
    .rd_data_o (acc_rd_data),
    .wr_en_i   (acc_wr_en),
    .wr_addr_i (acc_wr_addr),
    .wr_data_i (acc_wr_data)
  );

  softmax_accum u_accum (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .step_i        (step_i),
    .calc_en_i     (calc_en_i),
    .seq_len_i     (seq_len_i),
    .tile_s_i      (tile_s_i),
    .requant_oup_i (requant_oup_i),
    .max_i         (max_i),
    .max_rd_en_o   (max_rd_en[0]),
    .max_rd_addr_o (max_rd_addr[0]),
    .max_rd_data_i (max_rd_data[0]),
    .max_wr_en_o   (max_wr_en),
    .max_wr_addr_o (max_wr_addr),
    .max_wr_data_o (max_wr_data),
    .acc_rd_en_o   (acc_rd_en[0]),
    .acc_rd_addr_o (acc_rd_addr[0]),
    .acc_rd_data_i (acc_rd_data[0]),
    .acc_wr_en_o   (accum_wr_en),
    .acc_wr_addr_o (accum_wr_addr),
    .acc_wr_data_o (accum_wr_data),
    .push_o        (push),
    .push_data_o   (push_data)
  );

  softmax_div_dispatch u_dispatch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_data_i (push_data),
    .div_inp_o   (div_inp_o),
    .div_valid_o (div_valid_o),
    .div_ready_i (div_ready_i),
    .div_valid_i (div_valid_i),
    .div_ready_o (div_ready_o),
    .div_oup_i   (div_oup_i),
    .pop_o       (pop_softmax_fifo_o),
    .wr_en_o     (div_wr_en),
    .wr_addr_o   (div_wr_addr),
    .wr_data_o   (div_wr_data),
    .done_o      (softmax_done_o)
  );

  softmax_stream u_stream (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .calc_stream_soft_en_i (calc_stream_soft_en_i),
    .seq_len_i             (seq_len_i),
    .tile_y_i              (tile_y_i),
    .inner_tile_i          (inner_tile_i),
    .inp_i                 (inp_i),
    .rd_en_o               (stream_rd_en),
    .rd_addr_o             (stream_rd_addr),
    .acc_rd_data_i         (acc_rd_data[1]),
    .max_rd_data_i         (max_rd_data[1]),
    .inp_stream_soft_o     (inp_stream_soft_o)
  );

endmodule

`default_nettype wire

/* softmax_accum.sv */
// Softmax accumulation pipeline
// Four stages of exponent shifts, rescale of the partial sum and write back
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_accum
  import softmax_data_pkg::*;
  import softmax_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  step_e      step_i,
  input  logic       calc_en_i,
  input  seq_len_t   seq_len_i,
  input  tile_cnt_t  tile_s_i,
  // Scores and running row maximum arrive together with calc_en_i
  input  score_vec_t requant_oup_i,
  input  score_t     max_i,
  output logic       max_rd_en_o,
  output buf_addr_t  max_rd_addr_o,
  input  acc_t       max_rd_data_i,
  output logic       max_wr_en_o,
  output buf_addr_t  max_wr_addr_o,
  output acc_t       max_wr_data_o,
  output logic       acc_rd_en_o,
  output buf_addr_t  acc_rd_addr_o,
  input  acc_t       acc_rd_data_i,
  output logic       acc_wr_en_o,
  output buf_addr_t  acc_wr_addr_o,
  output acc_t       acc_wr_data_o,
  output logic       push_o,
  output acc_t       push_data_o
);

  counter_t count_q, tile_q;
  logic en0, first0, last0;
  logic [`SOFT_N-1:0] excl0;
  buf_addr_t addr0;

  logic en_q1, en_q2, en_q3;
  buf_addr_t addr_q1, addr_q2, addr_q3;
  logic first_q1, first_q2;
  logic last_q1, last_q2, last_q3;
  logic [`SOFT_N-1:0] excl_q1;
  score_vec_t inp_q1;
  score_t max_q1, max_q2;
  shift_t [`SOFT_N-1:0] shift_d, shift_q2;
  shift_t sum_shift_d, sum_shift_q2;
  acc_t exp_sum_d, exp_sum_q3;

  // Stage 0, counters and max buffer read
  assign en0    = calc_en_i && (step_i == QK);
  assign addr0  = buf_addr_t'(count_q % `SOFT_M);
  assign first0 = (tile_q == '0) && (count_q < `SOFT_M);
  assign last0  = (count_q >= `SOFT_PARTS - `SOFT_M) && (tile_q + 1'b1 == counter_t'(tile_s_i));

  always_comb begin
    for (int i = 0; i < `SOFT_N; i++) begin
      excl0[i] = (tile_q * `SOFT_M + `SOFT_N * (count_q / `SOFT_M) + i) >= seq_len_i;
    end
  end

  assign max_rd_en_o   = en0 && !first0;
  assign max_rd_addr_o = addr0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      tile_q  <= '0;
      en_q1   <= 1'b0;
      en_q2   <= 1'b0;
      en_q3   <= 1'b0;
    end else begin
      en_q1 <= en0;
      en_q2 <= en_q1;
      en_q3 <= en_q2;
      if (step_i != QK) begin
        count_q <= '0;
        tile_q  <= '0;
      end else if (calc_en_i) begin
        if (count_q == `SOFT_PARTS - 1) begin
          count_q <= '0;
          tile_q  <= tile_q + 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    inp_q1       <= requant_oup_i;
    max_q1       <= max_i;
    addr_q1      <= addr0;
    first_q1     <= first0;
    last_q1      <= last0;
    excl_q1      <= excl0;
    max_q2       <= max_q1;
    addr_q2      <= addr_q1;
    first_q2     <= first_q1;
    last_q2      <= last_q1;
    shift_q2     <= shift_d;
    sum_shift_q2 <= sum_shift_d;
    addr_q3      <= addr_q2;
    last_q3      <= last_q2;
    exp_sum_q3   <= exp_sum_d;
  end

  // Stage 1, lane shifts and rescale of the stored sum
  always_comb begin
    for (int i = 0; i < `SOFT_N; i++) begin
      // Shift of 15 marks a lane past the sequence length
      shift_d[i] = excl_q1[i] ? '1 : round_shift(max_q1, inp_q1[i]);
    end
    sum_shift_d = first_q1 ? '0 : round_shift(max_q1, max_rd_data_i[`SOFT_WI-1:0]);
  end

  assign acc_rd_en_o   = en_q1 && !first_q1;
  assign acc_rd_addr_o = addr_q1;

  // Stage 2, max write back and exponent sum
  always_comb begin
    exp_sum_d = '0;
    for (int i = 0; i < `SOFT_N; i++) begin
      if (shift_q2[i] != '1) begin
        exp_sum_d += acc_t'(256) >> shift_q2[i];
      end
    end
    if (!first_q2) begin
      exp_sum_d += acc_rd_data_i >> sum_shift_q2;
    end
  end

  assign max_wr_en_o   = en_q2;
  assign max_wr_addr_o = addr_q2;
  assign max_wr_data_o = {{(`SOFT_ACC_W - `SOFT_WI){1'b0}}, max_q2};

  // Stage 3, last tile rows go to the divider FIFO
  assign push_o        = en_q3 && last_q3;
  assign push_data_o   = exp_sum_q3;
  assign acc_wr_en_o   = en_q3 && !last_q3;
  assign acc_wr_addr_o = addr_q3;
  assign acc_wr_data_o = exp_sum_q3;

endmodule

`default_nettype wire

/* softmax_buffer.sv */
// Row buffer for maxima or sums
// One write port and two registered read ports
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_buffer
  import softmax_data_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic      [1:0]     rd_en_i,
  input  buf_addr_t [1:0]     rd_addr_i,
  output acc_t      [1:0]     rd_data_o,
  input  logic                wr_en_i,
  input  buf_addr_t           wr_addr_i,
  input  acc_t                wr_data_i
);

  acc_t mem_q [`SOFT_PARTS];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (rd_en_i[p]) begin
          rd_data_o[p] <= mem_q[rd_addr_i[p]];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* softmax_ctrl_pkg.sv */
// Control types of the softmax unit
`default_nettype none

`include "softmax_defines.svh"

package softmax_ctrl_pkg;

  typedef enum logic [1:0] {Idle, QK, AV} step_e;

  typedef logic [`SOFT_ADDR_W+3:0] seq_len_t;
  typedef logic [`SOFT_ADDR_W-1:0] tile_cnt_t;

endpackage

`default_nettype wire

/* softmax_data_pkg.sv */
// Data types of the softmax datapath
`default_nettype none

`include "softmax_defines.svh"

package softmax_data_pkg;

  typedef logic signed [`SOFT_WI-1:0] score_t;
  typedef logic [`SOFT_N-1:0][`SOFT_WI-1:0] score_vec_t;
  typedef logic [`SOFT_M-1:0][`SOFT_WI-1:0] row_vec_t;
  typedef logic [`SOFT_ACC_W-1:0] acc_t;
  typedef logic [`SOFT_SHIFT_W-1:0] shift_t;
  typedef logic [`SOFT_ADDR_W-1:0] buf_addr_t;
  typedef logic [`SOFT_ADDR_W+1:0] counter_t;
  typedef logic [$clog2(`SOFT_NUM_DIV)-1:0] div_sel_t;

  // Power-of-two exponent of a - b, five bits dropped and rounded on bit 4
  function automatic shift_t round_shift(input logic [`SOFT_WI-1:0] a,
                                         input logic [`SOFT_WI-1:0] b);
    logic [`SOFT_WI-1:0] diff;
    diff = a - b;
    return shift_t'(diff >> 5) + shift_t'(diff[4]);
  endfunction

endpackage

`default_nettype wire

/* softmax_defines.svh */
// Softmax unit sizes and widths
// Shared by the RTL and the testbench
`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

// Lanes per accumulation cycle
`define SOFT_N 4
// Row and tile size
`define SOFT_M 16
// Parts per tile, M*M/N
`define SOFT_PARTS 64

`define SOFT_WI 8
`define SOFT_ACC_W 16
`define SOFT_ADDR_W 6
`define SOFT_SHIFT_W 4

`define SOFT_NUM_DIV 2
`define SOFT_FIFO_DEPTH 4

// Dividend of the external dividers, quotient is dividend / sum
`define SOFT_DIV_DIVIDEND 65535

`endif

/* softmax_div_dispatch.sv */
// Round-robin issue of row sums to the external dividers
// Quotients are collected in the same order and written to rows 0 to M-1
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_div_dispatch
  import softmax_data_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            push_i,
  input  acc_t                            push_data_i,
  output acc_t                            div_inp_o,
  output logic [`SOFT_NUM_DIV-1:0]        div_valid_o,
  input  logic [`SOFT_NUM_DIV-1:0]        div_ready_i,
  input  logic [`SOFT_NUM_DIV-1:0]        div_valid_i,
  output logic [`SOFT_NUM_DIV-1:0]        div_ready_o,
  input  acc_t [`SOFT_NUM_DIV-1:0]        div_oup_i,
  output logic                            pop_o,
  output logic                            wr_en_o,
  output buf_addr_t                       wr_addr_o,
  output acc_t                            wr_data_o,
  output logic                            done_o
);

  localparam int unsigned LastDiv = `SOFT_NUM_DIV - 1;

  logic fifo_empty, accept, take;
  div_sel_t rd_sel_q, wr_sel_q;
  buf_addr_t addr_q;
  // Quotients still owed by the dividers
  counter_t pending_q;

  softmax_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push_i),
    .data_i  (push_data_i),
    .pop_i   (accept),
    .data_o  (div_inp_o),
    .full_o  (),
    .empty_o (fifo_empty)
  );

  always_comb begin
    div_valid_o           = '0;
    div_valid_o[rd_sel_q] = !fifo_empty;
    div_ready_o           = '0;
    div_ready_o[wr_sel_q] = (pending_q != '0);
  end

  assign accept    = !fifo_empty && div_ready_i[rd_sel_q];
  assign take      = (pending_q != '0) && div_valid_i[wr_sel_q];
  assign pop_o     = accept;
  assign wr_en_o   = take;
  assign wr_addr_o = addr_q;
  assign wr_data_o = div_oup_i[wr_sel_q];
  assign done_o    = take && (addr_q == `SOFT_M - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_sel_q  <= '0;
      wr_sel_q  <= '0;
      addr_q    <= '0;
      pending_q <= '0;
    end else begin
      if (accept) begin
        rd_sel_q <= (rd_sel_q == LastDiv) ? '0 : rd_sel_q + 1'b1;
      end
      if (take) begin
        wr_sel_q <= (wr_sel_q == LastDiv) ? '0 : wr_sel_q + 1'b1;
        addr_q   <= (addr_q == `SOFT_M - 1) ? '0 : addr_q + 1'b1;
      end
      pending_q <= pending_q + counter_t'(accept) - counter_t'(take);
    end
  end

endmodule

`default_nettype wire

/* softmax_fifo.sv */
// FIFO of finished row sums waiting for a divider
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_fifo
  import softmax_data_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  acc_t data_i,
  input  logic pop_i,
  output acc_t data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PtrW = $clog2(`SOFT_FIFO_DEPTH);
  localparam int unsigned LastEntry = `SOFT_FIFO_DEPTH - 1;

  acc_t mem_q [`SOFT_FIFO_DEPTH];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0] usage_q;
  logic do_push, do_pop;

  assign full_o  = (usage_q == `SOFT_FIFO_DEPTH);
  assign empty_o = (usage_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  // Head entry straight from storage, no fall-through
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastEntry) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastEntry) ? '0 : rd_ptr_q + 1'b1;
      end
      usage_q <= usage_q + {{PtrW{1'b0}}, do_push} - {{PtrW{1'b0}}, do_pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* softmax_stream.sv */
// Streaming softmax normalization
// Inverse sums shifted by each score's distance from the row maximum
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_stream
  import softmax_data_pkg::*;
  import softmax_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      calc_stream_soft_en_i,
  input  seq_len_t  seq_len_i,
  input  counter_t  tile_y_i,
  input  counter_t  inner_tile_i,
  // Row scores, presented one cycle after the enable with the read data
  input  row_vec_t  inp_i,
  output logic      rd_en_o,
  output buf_addr_t rd_addr_o,
  input  acc_t      acc_rd_data_i,
  input  acc_t      max_rd_data_i,
  output row_vec_t  inp_stream_soft_o
);

  counter_t cnt_q, row_q, tile_y_q, inner_tile_q;
  logic en_q;
  logic row_off;

  assign rd_en_o   = calc_stream_soft_en_i;
  assign rd_addr_o = buf_addr_t'(cnt_q % `SOFT_M);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      en_q  <= 1'b0;
    end else begin
      en_q <= calc_stream_soft_en_i;
      if (calc_stream_soft_en_i) begin
        cnt_q <= (cnt_q == `SOFT_PARTS - 1) ? '0 : cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_stream_soft_en_i) begin
      row_q        <= counter_t'(cnt_q % `SOFT_M);
      tile_y_q     <= tile_y_i;
      inner_tile_q <= inner_tile_i;
    end
  end

  assign row_off = (tile_y_q * `SOFT_M + row_q) >= seq_len_i;

  always_comb begin
    acc_t quot;
    shift_t sh;
    quot              = '0;
    sh                = '0;
    inp_stream_soft_o = '0;
    if (en_q && !row_off) begin
      for (int i = 0; i < `SOFT_M; i++) begin
        // Columns past the sequence length stay zero
        if (inner_tile_q * `SOFT_M + i < seq_len_i) begin
          sh                   = round_shift(max_rd_data_i[`SOFT_WI-1:0], inp_i[i]);
          quot                 = acc_rd_data_i >> sh;
          inp_stream_soft_o[i] = quot[`SOFT_WI-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
softmax_data_pkg.sv
softmax_ctrl_pkg.sv
softmax_buffer.sv
softmax_accum.sv
softmax_fifo.sv
softmax_div_dispatch.sv
softmax_stream.sv
ita_softmax_top.sv
tb_ita_softmax_asserts.sv
tb_ita_softmax.sv

/* tb_ita_softmax.sv */
// Testbench for the softmax unit
// Table driven tests with a divider model and a row sum reference model
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module tb_ita_softmax
  import softmax_data_pkg::*;
  import softmax_ctrl_pkg::*;
();

  localparam int NUM_TESTS = 4;

  typedef struct packed {
    seq_len_t  seq_len;
    tile_cnt_t tile_s;
    counter_t  tile_y;
    counter_t  inner_tile;
    logic [7:0] ready_pat;
  } test_t;

  logic clk_i, rst_ni, calc_en_i, calc_stream_soft_en_i;
  step_e step_i;
  seq_len_t seq_len_i;
  tile_cnt_t tile_s_i;
  score_vec_t requant_oup_i;
  score_t max_i;
  row_vec_t inp_i, inp_stream_soft_o;
  counter_t tile_y_i, inner_tile_i;
  acc_t div_inp_o;
  logic [`SOFT_NUM_DIV-1:0] div_valid_o, div_ready_i, div_valid_i, div_ready_o;
  acc_t [`SOFT_NUM_DIV-1:0] div_oup_i;
  logic pop_softmax_fifo_o, softmax_done_o;

  test_t tests [NUM_TESTS];
  integer seed = 98;
  acc_t sum_m [`SOFT_M];
  score_t max_m [`SOFT_M];
  logic [7:0] ready_pat;
  int issue_cnt, take_cnt, done_cnt, pop_cnt;
  logic [`SOFT_NUM_DIV-1:0] busy, prev_valid;
  int wait_cnt [`SOFT_NUM_DIV];
  acc_t res [`SOFT_NUM_DIV];
  acc_t prev_inp;
  logic prev_acc;

  ita_softmax_top UUT (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic report_error(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) report_error($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_row(input string name, input row_vec_t got, input row_vec_t exp);
    if (got !== exp) report_error($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_flags(input string name, input logic [`SOFT_NUM_DIV-1:0] got,
                             input logic [`SOFT_NUM_DIV-1:0] exp);
    if (got !== exp) report_error($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // Exponent from the difference, five bits dropped and rounded on bit 4
  function automatic shift_t exp_shift(input score_t hi, input score_t lo);
    logic [7:0] d;
    d = hi - lo;
    return shift_t'(d[7:5]) + shift_t'(d[4]);
  endfunction

  // Transfers and quotients as seen at the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (UUT.u_asserts.fail_cnt != 0) report_error("A bound assertion failed");
      if (prev_valid != '0 && !prev_acc) begin
        check_flags("div_valid_o", div_valid_o, prev_valid);
        check_acc("div_inp_o", div_inp_o, prev_inp);
      end
      if (!$onehot0(div_ready_o)) report_error("div_ready_o has more than one bit set");
      prev_acc = 1'b0;
      for (int k = 0; k < `SOFT_NUM_DIV; k++) begin
        if (div_valid_o[k] && div_ready_i[k]) begin
          if (issue_cnt >= `SOFT_M || k != issue_cnt % `SOFT_NUM_DIV)
            report_error("row sum issued to the wrong divider or too many rows issued");
          check_acc("div_inp_o", div_inp_o, sum_m[issue_cnt]);
          issue_cnt++;
          busy[k] = 1'b1;
          wait_cnt[k] = 3;
          res[k] = `SOFT_DIV_DIVIDEND / div_inp_o;
          prev_acc = 1'b1;
        end
        if (div_valid_i[k] && div_ready_o[k]) begin
          busy[k] = 1'b0;
          take_cnt++;
        end
      end
      // A pop goes with every transfer to a divider
      check_flags("pop_softmax_fifo_o", {1'b0, pop_softmax_fifo_o},
                  {1'b0, |(div_valid_o & div_ready_i)});
      if (pop_softmax_fifo_o) pop_cnt++;
      if (softmax_done_o) begin
        done_cnt++;
        if (take_cnt != `SOFT_M) report_error("softmax_done_o before the last quotient");
      end
      prev_valid = div_valid_o;
      prev_inp = div_inp_o;
    end
  end

  // Divider model, answers three cycles after acceptance
  always @(negedge clk_i) begin
    ready_pat = {ready_pat[6:0], ready_pat[7]};
    for (int k = 0; k < `SOFT_NUM_DIV; k++) begin
      if (busy[k] && wait_cnt[k] > 0) begin
        wait_cnt[k]--;
        if (wait_cnt[k] == 0) begin
          div_valid_i[k] = 1'b1;
          div_oup_i[k] = res[k];
        end
      end
      if (!busy[k]) div_valid_i[k] = 1'b0;
      div_ready_i[k] = !busy[k] && ready_pat[k];
    end
  end

  initial begin
    #(NUM_TESTS * 2000 * 40);
    $display("Timeout: the test did not finish in time");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  initial begin
    score_vec_t sc;
    row_vec_t x, exp_row;
    score_t m;
    acc_t lanes, q, v;
    int r, grp, issued;
    logic last;
    // seq_len, tile_s, tile_y, inner_tile, divider ready pattern
    tests[0] = '{48, 3, 0, 2, 8'hff};
    tests[1] = '{40, 3, 2, 2, 8'b1011_0110};
    tests[2] = '{20, 2, 1, 1, 8'b0110_0101};
    tests[3] = '{16, 1, 0, 0, 8'b1100_1001};
    rst_ni = 1'b0;
    step_i = Idle;
    calc_en_i = 1'b0;
    seq_len_i = '0;
    tile_s_i = '0;
    requant_oup_i = '0;
    max_i = '0;
    calc_stream_soft_en_i = 1'b0;
    inp_i = '0;
    tile_y_i = '0;
    inner_tile_i = '0;
    div_ready_i = '0;
    div_valid_i = '0;
    div_oup_i = '0;
    busy = '0;
    prev_valid = '0;
    prev_acc = 1'b0;
    ready_pat = 8'hff;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_flags("div_valid_o", div_valid_o, '0);
    check_flags("div_ready_o", div_ready_o, '0);
    check_flags("softmax_done_o", {1'b0, softmax_done_o}, '0);
    check_flags("pop_softmax_fifo_o", {1'b0, pop_softmax_fifo_o}, '0);
    check_row("inp_stream_soft_o", inp_stream_soft_o, '0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(negedge clk_i);
      issue_cnt = 0;
      take_cnt = 0;
      done_cnt = 0;
      pop_cnt = 0;
      issued = 0;
      ready_pat = tests[t].ready_pat;
      seq_len_i = tests[t].seq_len;
      tile_s_i = tests[t].tile_s;
      step_i = QK;
      for (int tl = 0; tl < tests[t].tile_s; tl++) begin
        for (int c = 0; c < `SOFT_PARTS; c++) begin
          r = c % `SOFT_M;
          grp = c / `SOFT_M;
          last = (tl == tests[t].tile_s - 1) && (grp == 3);
          // Keep the FIFO from overflowing on the last tile
          while (last && issued - pop_cnt >= `SOFT_FIFO_DEPTH) begin
            calc_en_i = 1'b0;
            @(negedge clk_i);
          end
          for (int i = 0; i < `SOFT_N; i++) sc[i] = score_t'($random(seed) % 64);
          m = (tl == 0 && grp == 0) ? score_t'(sc[0]) : max_m[r];
          for (int i = 0; i < `SOFT_N; i++) if (score_t'(sc[i]) > m) m = score_t'(sc[i]);
          lanes = '0;
          for (int i = 0; i < `SOFT_N; i++)
            if (tl * `SOFT_M + grp * `SOFT_N + i < tests[t].seq_len)
              lanes += acc_t'(256) >> exp_shift(m, score_t'(sc[i]));
          if (tl == 0 && grp == 0) sum_m[r] = lanes;
          else sum_m[r] = lanes + (sum_m[r] >> exp_shift(m, max_m[r]));
          max_m[r] = m;
          if (last) issued++;
          calc_en_i = 1'b1;
          requant_oup_i = sc;
          max_i = m;
          @(negedge clk_i);
        end
      end
      calc_en_i = 1'b0;
      step_i = Idle;
      while (done_cnt == 0) @(negedge clk_i);
      for (int row = 0; row < `SOFT_M; row++) begin
        calc_stream_soft_en_i = 1'b1;
        tile_y_i = tests[t].tile_y;
        inner_tile_i = tests[t].inner_tile;
        @(negedge clk_i);
        calc_stream_soft_en_i = 1'b0;
        for (int i = 0; i < `SOFT_M; i++) x[i] = max_m[row] - score_t'($random(seed) & 63);
        inp_i = x;
        q = `SOFT_DIV_DIVIDEND / sum_m[row];
        exp_row = '0;
        if (tests[t].tile_y * `SOFT_M + row < tests[t].seq_len) begin
          for (int i = 0; i < `SOFT_M; i++) begin
            v = q >> exp_shift(max_m[row], score_t'(x[i]));
            if (tests[t].inner_tile * `SOFT_M + i < tests[t].seq_len) exp_row[i] = v[7:0];
          end
        end
        @(posedge clk_i);
        check_row("inp_stream_soft_o", inp_stream_soft_o, exp_row);
        @(negedge clk_i);
        inp_i = '0;
      end
      if (done_cnt != 1) report_error("softmax_done_o did not pulse exactly once");
    end
    if (UUT.u_asserts.fail_cnt != 0) begin
      report_error("A bound assertion failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb_ita_softmax_asserts.sv */
// Concurrent checks on the softmax top level
// FIFO overflow, divider request stability and one-hot quotient ready
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module tb_ita_softmax_asserts (
  input wire                      clk_i,
  input wire                      rst_ni,
  input wire                      push_i,
  input wire                      fifo_full_i,
  input wire [`SOFT_ACC_W-1:0]    div_inp_o,
  input wire [`SOFT_NUM_DIV-1:0]  div_valid_o,
  input wire [`SOFT_NUM_DIV-1:0]  div_ready_i,
  input wire [`SOFT_NUM_DIV-1:0]  div_ready_o
);

  // Number of failed properties, read by the testbench
  int fail_cnt = 0;

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && fifo_full_i))
    else begin
      $error("push into a full FIFO");
      fail_cnt++;
    end

  // Request waits unchanged until a divider takes it
  valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (div_valid_o != '0 && (div_valid_o & div_ready_i) == '0)
    |=> (div_valid_o == $past(div_valid_o) && div_inp_o == $past(div_inp_o)))
    else begin
      $error("divider request changed before acceptance");
      fail_cnt++;
    end

  ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(div_ready_o))
    else begin
      $error("div_ready_o is not one-hot");
      fail_cnt++;
    end

endmodule

bind ita_softmax_top tb_ita_softmax_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .push_i      (push),
  .fifo_full_i (u_dispatch.u_fifo.full_o),
  .div_inp_o   (div_inp_o),
  .div_valid_o (div_valid_o),
  .div_ready_i (div_ready_i),
  .div_ready_o (div_ready_o)
);

`default_nettype wire
